// ==== sim/tinker_vectors.txt ====
# records: T <test name> | I <instruction word, hex> | W <rd, decimal> <value, hex> | E
# several records share a line; programs start at 0x2000, one word every 4 bytes
T alu
I c8400064 I c8800ffd I c0c22000 I d1022000 I e1422000 I 01822000
I 09c22000 I 12022000 I 1a420000 I 3a820004 I 2ac4003c I cb000003
I 3342c000 I 2384c000 I 8bc40000 I 93c00abc I d8400ffb I 78000000
W 1 64 W 2 fffffffffffffffd W 3 61 W 4 67
W 5 fffffffffffffed4 W 6 64 W 7 fffffffffffffffd
W 8 ffffffffffffff99 W 9 ffffffffffffff9b W 10 640
W 11 f W 12 3 W 13 320 W 14 1fffffffffffffff
W 15 fffffffffffffffd W 15 fffffffffffffabc W 1 69
E
T forward
I c8400005 I c0821000 I c8800007 I d8800002 I d0c41000
I e0462000 I 88020000 I c1003000 I 78000000
W 1 5 W 2 a W 2 11 W 2 f W 3 a W 1 96 W 0 96 W 4 a0
E
T memory
I c8400100 I 908005a5 I 98440008 I 80c20008 I c1062000 I 81420010 I 78000000
W 1 100 W 2 5a5 W 3 5a5 W 4 b4a W 5 0
E
T branch
I c840000c I 5000000c I cd000001 I cd000001 I 48400000 I cd000001 I cd000001
I c8800406 I 38840003 I 40800000 I cd000001 I cd000001 I c8800010 I 58820000
I cd000001 I cd000001 I 58800000 I c9400001 I c9800fff I 708c1000 I c9400001
I c8800024 I 70826000 I cd000001 I cd000001 I c9400001 I 78000000
W 1 c W 2 406 W 2 2030 W 2 2040 W 5 1
W 6 ffffffffffffffff W 5 2 W 2 2064 W 5 3
E
T halt_reset
I 80c20108 I c104f000 I 78000000 I c9c00001 I c9c00001
W 3 0 W 4 0
E

// ==== compile.f ====
hdl/tinker_isa_pkg.sv
hdl/tinker_pipe_pkg.sv
hdl/tinker_regfile.sv
hdl/tinker_forward.sv
hdl/tinker_data_mem.sv
hdl/tinker_fetch.sv
hdl/tinker_decode_stage.sv
hdl/tinker_execute_stage.sv
hdl/tinker_mem_stage.sv
hdl/tinker_core.sv
sim/tinker_core_tb.sv

// ==== Bender.yml ====
package:
  name: tinker_core

sources:
  - hdl/tinker_isa_pkg.sv
  - hdl/tinker_pipe_pkg.sv
  - hdl/tinker_regfile.sv
  - hdl/tinker_forward.sv
  - hdl/tinker_data_mem.sv
  - hdl/tinker_fetch.sv
  - hdl/tinker_decode_stage.sv
  - hdl/tinker_execute_stage.sv
  - hdl/tinker_mem_stage.sv
  - hdl/tinker_core.sv
  - target: simulation
    files:
      - sim/tinker_core_tb.sv

// ==== sim/tinker_core_tb.sv ====
module tinker_core_tb;

    // opcode 0x0f in the top five bits
    localparam logic [31:0] halt_word = 32'h7800_0000;

    logic                 clk;
    logic                 reset;
    logic [63:0]          imem_addr;
    logic [31:0]          imem_data;
    tinker_pipe_pkg::wb_t wb;
    logic                 hlt;

    // parsed vectors, flat queues with per-test bounds
    logic [8*16-1:0] names [$];
    logic [31:0]     prog [$];
    logic [4:0]      exp_rd [$];
    logic [63:0]     exp_val [$];
    int              i_first [$];
    int              i_last [$];
    int              w_first [$];
    int              w_last [$];

    // program of the running test
    logic [31:0]     prog_mem [256];
    int              prog_len;
    logic [63:0]     offset;
    int              err_count;
    int              fail_count;
    bit              parsed;

    tinker_core u_dut (
        .clk       (clk),
        .reset     (reset),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .wb        (wb),
        .hlt       (hlt)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // instruction port, same-cycle answer, halt past the end
    always_comb begin
        offset    = imem_addr - 64'h2000;
        imem_data = halt_word;
        if (imem_addr >= 64'h2000 && offset[1:0] == 2'b00 && (offset >> 2) < 64'(prog_len)) begin
            imem_data = prog_mem[offset[9:2]];
        end
    end

    task automatic compare(input logic [8*16-1:0] tname, input string what,
                           input logic [63:0] expected, input logic [63:0] actual);
        if (actual !== expected) begin
            $display("ERROR %0s %0s: expected %h, got %h", tname, what, expected, actual);
            err_count++;
        end
    endtask

    task automatic load_vectors();
        int              fd;
        int              r;
        int              rd;
        logic [7:0]      tag;
        logic [8*16-1:0] tname;
        logic [31:0]     word;
        logic [63:0]     val;
        logic [8*128-1:0] line;
        fd = $fopen("sim/tinker_vectors.txt", "r");
        if (fd == 0) begin
            $display("cannot open sim/tinker_vectors.txt");
            err_count++;
        end else begin
            // token stream, one tag then its fields
            while ($fscanf(fd, " %s", tag) == 1) begin
                case (tag)
                    "#": r = $fgets(line, fd);
                    "T": begin
                        r = $fscanf(fd, " %s", tname);
                        names.push_back(tname);
                        i_first.push_back(prog.size());
                        w_first.push_back(exp_rd.size());
                    end
                    "I": begin
                        r = $fscanf(fd, " %h", word);
                        prog.push_back(word);
                    end
                    "W": begin
                        r = $fscanf(fd, " %d %h", rd, val);
                        exp_rd.push_back(5'(rd));
                        exp_val.push_back(val);
                    end
                    "E": begin
                        i_last.push_back(prog.size());
                        w_last.push_back(exp_rd.size());
                    end
                    default: begin
                        $display("unknown record tag in vectors file");
                        err_count++;
                    end
                endcase
            end
            $fclose(fd);
        end
        if (names.size() == 0 || names.size() != i_last.size()) begin
            $display("vectors file has no tests or a test without an end record");
            err_count++;
        end
    endtask

    task automatic run_test(input int t);
        int              wi;
        int              k;
        int              errs_at_start;
        logic [8*16-1:0] tname;
        tname         = names[t];
        errs_at_start = err_count;
        @(posedge clk);
        #5;
        reset    = 1'b1;
        prog_len = i_last[t] - i_first[t];
        for (k = 0; k < prog_len; k++) begin
            prog_mem[k] = prog[i_first[t] + k];
        end
        repeat (2) @(posedge clk);
        #5;
        reset = 1'b0;
        // reset state before the first edge
        compare(tname, "pc after reset", 64'h2000, imem_addr);
        compare(tname, "wb valid after reset", 64'd0, 64'(wb.valid));
        compare(tname, "hlt after reset", 64'd0, 64'(hlt));
        wi = w_first[t];
        while (hlt !== 1'b1) begin
            @(negedge clk);
            if (wb.valid) begin
                if (wi < w_last[t]) begin
                    compare(tname, "wb rd", 64'(exp_rd[wi]), 64'(wb.rd));
                    compare(tname, "wb data", exp_val[wi], wb.data);
                    wi++;
                end else begin
                    $display("%0s: unexpected writeback to r%0d", tname, wb.rd);
                    err_count++;
                end
            end
        end
        // nothing retires once halted
        repeat (4) begin
            @(negedge clk);
            if (wb.valid) begin
                $display("%0s: writeback to r%0d after halt", tname, wb.rd);
                err_count++;
            end
        end
        compare(tname, "hlt held", 64'd1, 64'(hlt));
        if (wi != w_last[t]) begin
            $display("%0s: %0d expected writebacks never happened", tname, w_last[t] - wi);
            err_count++;
        end
        if (err_count == errs_at_start) begin
            $display("test %0s: ok", tname);
        end else begin
            $display("test %0s: %0d errors", tname, err_count - errs_at_start);
            fail_count++;
        end
    endtask

    initial begin
        int t;
        reset      = 1'b1;
        prog_len   = 0;
        err_count  = 0;
        fail_count = 0;
        parsed     = 1'b0;
        load_vectors();
        parsed = 1'b1;
        for (t = 0; t < i_last.size(); t++) begin
            run_test(t);
        end
        $display("%0d tests, %0d failed, %0d errors", i_last.size(), fail_count, err_count);
        if (err_count == 0 && fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // cycle budget from program sizes plus slack per test
    initial begin
        int limit;
        wait (parsed);
        limit = (prog.size() + 20 * names.size()) * 20 + 20;
        repeat (limit) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", limit);
        $display("sim failed");
        $finish;
    end

endmodule

// ==== hdl/tinker_core.sv ====
module tinker_core #(
    parameter logic [tinker_isa_pkg::xlen-1:0] reset_pc   = 64'h2000,
    parameter int                              dmem_words = 1024
) (
    input  logic                            clk,
    input  logic                            reset,
    output logic [tinker_isa_pkg::xlen-1:0] imem_addr,
    input  logic [tinker_isa_pkg::ilen-1:0] imem_data,
    output tinker_pipe_pkg::wb_t            wb,
    output logic                            hlt
);

    tinker_pipe_pkg::fetch_t         if_id;
    tinker_pipe_pkg::decoded_t       id_ex;
    tinker_pipe_pkg::ex_mem_t        ex_mem;
    logic [tinker_isa_pkg::xlen-1:0] mem_result;

    tinker_fetch #(
        .reset_pc  (reset_pc)
    ) u_fetch (
        .clk       (clk),
        .reset     (reset),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .ex_mem    (ex_mem),
        .if_id     (if_id)
    );

    tinker_decode_stage u_decode (
        .clk    (clk),
        .reset  (reset),
        .if_id  (if_id),
        .ex_mem (ex_mem),
        .wb     (wb),
        .id_ex  (id_ex)
    );

    // ex/mem also feeds the kill logic of fetch and decode
    tinker_execute_stage u_execute (
        .clk        (clk),
        .reset      (reset),
        .id_ex      (id_ex),
        .mem_result (mem_result),
        .wb         (wb),
        .ex_mem     (ex_mem)
    );

    tinker_mem_stage #(
        .dmem_words (dmem_words)
    ) u_mem (
        .clk        (clk),
        .reset      (reset),
        .ex_mem     (ex_mem),
        .mem_result (mem_result),
        .wb         (wb),
        .hlt        (hlt)
    );

endmodule

// ==== hdl/tinker_mem_stage.sv ====
module tinker_mem_stage #(
    parameter int dmem_words = 1024
) (
    input  logic                            clk,
    input  logic                            reset,
    input  tinker_pipe_pkg::ex_mem_t        ex_mem,
    output logic [tinker_isa_pkg::xlen-1:0] mem_result,
    output tinker_pipe_pkg::wb_t            wb,
    output logic                            hlt
);

    logic [tinker_isa_pkg::xlen-1:0] read_data;
    // halt sitting in mem/wb
    logic                            halt_q;

    tinker_data_mem #(
        .dmem_words (dmem_words)
    ) u_dmem (
        .clk        (clk),
        .reset      (reset),
        .write_en   (ex_mem.valid & ex_mem.mem_write),
        .addr       (ex_mem.addr),
        .write_data (ex_mem.store_data),
        .read_data  (read_data)
    );

    // also the forwarding source for execute
    assign mem_result = ex_mem.is_load ? read_data : ex_mem.result;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb     <= '0;
            halt_q <= 1'b0;
            hlt    <= 1'b0;
        end else begin
            wb.valid <= ex_mem.valid & ex_mem.reg_write;
            wb.rd    <= ex_mem.rd;
            wb.data  <= mem_result;
            halt_q   <= ex_mem.valid & ex_mem.halt;
            // sticky until reset
            if (halt_q) begin
                hlt <= 1'b1;
            end
        end
    end

endmodule

// ==== hdl/tinker_execute_stage.sv ====
module tinker_execute_stage (
    input  logic                            clk,
    input  logic                            reset,
    input  tinker_pipe_pkg::decoded_t       id_ex,
    input  logic [tinker_isa_pkg::xlen-1:0] mem_result,
    input  tinker_pipe_pkg::wb_t            wb,
    output tinker_pipe_pkg::ex_mem_t        ex_mem
);

    logic [tinker_isa_pkg::xlen-1:0] rd_fwd;
    logic [tinker_isa_pkg::xlen-1:0] rs_fwd;
    logic [tinker_isa_pkg::xlen-1:0] rt_fwd;
    logic [tinker_isa_pkg::xlen-1:0] opnd_b;
    tinker_pipe_pkg::ex_mem_t        nxt;
    logic                            op_ok;
    logic                            kill;

    tinker_forward u_forward (
        .id_ex      (id_ex),
        .ex_mem     (ex_mem),
        .mem_result (mem_result),
        .wb         (wb),
        .rd_fwd     (rd_fwd),
        .rs_fwd     (rs_fwd),
        .rt_fwd     (rt_fwd)
    );

    assign opnd_b = id_ex.lit_sel ? id_ex.literal : rt_fwd;
    assign kill   = ex_mem.valid & (ex_mem.redirect | ex_mem.halt);

    always_comb begin
        nxt           = '0;
        op_ok         = 1'b1;
        nxt.valid     = id_ex.valid & ~kill;
        nxt.rd        = id_ex.rd;
        nxt.reg_write = 1'b1;
        // brr jumps straight to rd
        nxt.target    = rd_fwd;
        case (id_ex.op)
            tinker_isa_pkg::op_add:    nxt.result = rs_fwd + opnd_b;
            tinker_isa_pkg::op_addi:   nxt.result = rd_fwd + opnd_b;
            tinker_isa_pkg::op_sub:    nxt.result = rs_fwd - opnd_b;
            tinker_isa_pkg::op_subi:   nxt.result = rd_fwd - opnd_b;
            tinker_isa_pkg::op_mul:    nxt.result = rs_fwd * opnd_b;
            tinker_isa_pkg::op_and:    nxt.result = rs_fwd & opnd_b;
            tinker_isa_pkg::op_or:     nxt.result = rs_fwd | opnd_b;
            tinker_isa_pkg::op_xor:    nxt.result = rs_fwd ^ opnd_b;
            tinker_isa_pkg::op_not:    nxt.result = ~rs_fwd;
            tinker_isa_pkg::op_shftr:  nxt.result = rs_fwd >> opnd_b;
            tinker_isa_pkg::op_shftri: nxt.result = rs_fwd >> opnd_b;
            tinker_isa_pkg::op_shftl:  nxt.result = rs_fwd << opnd_b;
            tinker_isa_pkg::op_shftli: nxt.result = rs_fwd << opnd_b;
            tinker_isa_pkg::op_mov:    nxt.result = rs_fwd;
            // upper bits of rd survive
            tinker_isa_pkg::op_movl:   nxt.result = {rd_fwd[63:12], id_ex.literal[11:0]};
            tinker_isa_pkg::op_load: begin
                nxt.is_load = 1'b1;
                nxt.addr    = rs_fwd + opnd_b;
            end
            tinker_isa_pkg::op_store: begin
                nxt.reg_write  = 1'b0;
                nxt.mem_write  = 1'b1;
                nxt.addr       = rd_fwd + opnd_b;
                nxt.store_data = rs_fwd;
            end
            tinker_isa_pkg::op_brr: begin
                nxt.reg_write = 1'b0;
                nxt.redirect  = 1'b1;
            end
            tinker_isa_pkg::op_brr_rel: begin
                nxt.reg_write = 1'b0;
                nxt.redirect  = 1'b1;
                nxt.target    = id_ex.pc + rd_fwd;
            end
            tinker_isa_pkg::op_br_rel_lit: begin
                nxt.reg_write = 1'b0;
                nxt.redirect  = 1'b1;
                nxt.target    = id_ex.pc + opnd_b;
            end
            tinker_isa_pkg::op_brnz: begin
                nxt.reg_write = 1'b0;
                nxt.redirect  = rs_fwd != '0;
            end
            // not taken falls through with no redirect
            tinker_isa_pkg::op_brgt: begin
                nxt.reg_write = 1'b0;
                nxt.redirect  = $signed(rs_fwd) > $signed(rt_fwd);
            end
            tinker_isa_pkg::op_halt: begin
                nxt.reg_write = 1'b0;
                nxt.halt      = 1'b1;
            end
            default: begin
                nxt.reg_write = 1'b0;
                op_ok         = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ex_mem <= '0;
        end else begin
            ex_mem <= nxt;
        end
    end

    // instruction port must not feed undefined opcodes into a live slot
    a_known_op: assert property (@(posedge clk) disable iff (reset)
        id_ex.valid |-> op_ok);

endmodule

// ==== hdl/tinker_decode_stage.sv ====
module tinker_decode_stage (
    input  logic                      clk,
    input  logic                      reset,
    input  tinker_pipe_pkg::fetch_t   if_id,
    input  tinker_pipe_pkg::ex_mem_t  ex_mem,
    input  tinker_pipe_pkg::wb_t      wb,
    output tinker_pipe_pkg::decoded_t id_ex
);

    tinker_isa_pkg::instr_t          ins;
    logic                            lit_sel;
    logic                            kill;
    logic [tinker_isa_pkg::xlen-1:0] rd_val;
    logic [tinker_isa_pkg::xlen-1:0] rs_val;
    logic [tinker_isa_pkg::xlen-1:0] rt_val;

    assign ins  = if_id.instr;
    assign kill = ex_mem.valid & (ex_mem.redirect | ex_mem.halt);

    // literal forms replace rt by the 12-bit field
    assign lit_sel = ins.op inside {
        tinker_isa_pkg::op_addi, tinker_isa_pkg::op_subi,
        tinker_isa_pkg::op_shftri, tinker_isa_pkg::op_shftli,
        tinker_isa_pkg::op_movl, tinker_isa_pkg::op_br_rel_lit,
        tinker_isa_pkg::op_load, tinker_isa_pkg::op_store};

    tinker_regfile u_regfile (
        .clk     (clk),
        .reset   (reset),
        .rd_addr (ins.rd),
        .rs_addr (ins.rs),
        .rt_addr (ins.rt),
        .rd_val  (rd_val),
        .rs_val  (rs_val),
        .rt_val  (rt_val),
        .wb      (wb)
    );

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            id_ex <= '0;
        end else begin
            // squashed behind a taken branch or halt
            id_ex.valid   <= if_id.valid & ~kill;
            id_ex.op      <= ins.op;
            id_ex.rd      <= ins.rd;
            id_ex.rs      <= ins.rs;
            id_ex.rt      <= ins.rt;
            id_ex.lit_sel <= lit_sel;
            id_ex.literal <= {{52{ins.lit[11]}}, ins.lit};
            id_ex.pc      <= if_id.pc;
            id_ex.rd_val  <= rd_val;
            id_ex.rs_val  <= rs_val;
            id_ex.rt_val  <= rt_val;
        end
    end

endmodule

// ==== hdl/tinker_fetch.sv ====
module tinker_fetch #(
    parameter logic [tinker_isa_pkg::xlen-1:0] reset_pc = 64'h2000
) (
    input  logic                            clk,
    input  logic                            reset,
    output logic [tinker_isa_pkg::xlen-1:0] imem_addr,
    input  logic [tinker_isa_pkg::ilen-1:0] imem_data,
    input  tinker_pipe_pkg::ex_mem_t        ex_mem,
    output tinker_pipe_pkg::fetch_t         if_id
);

    logic [tinker_isa_pkg::xlen-1:0] pc;
    // set once halt reaches ex/mem, cleared only by reset
    logic                            stopped;
    logic                            kill;

    // instruction port answers in the same cycle
    assign imem_addr = pc;
    assign kill      = ex_mem.valid & (ex_mem.redirect | ex_mem.halt);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc      <= reset_pc;
            stopped <= 1'b0;
            if_id   <= '0;
        end else begin
            if_id.pc    <= pc;
            if_id.instr <= tinker_isa_pkg::instr_t'(imem_data);
            // word in flight behind a taken branch is dropped too
            if_id.valid <= ~stopped & ~kill;
            if (kill) begin
                if (ex_mem.halt) begin
                    stopped <= 1'b1;
                end else begin
                    pc <= ex_mem.target;
                end
            end else if (!stopped) begin
                pc <= pc + 64'd4;
            end
        end
    end

    // execute must never flag a jump and a halt on one entry
    a_redirect_halt: assert property (@(posedge clk) disable iff (reset)
        ex_mem.valid |-> !(ex_mem.redirect && ex_mem.halt));

endmodule

// ==== hdl/tinker_data_mem.sv ====
module tinker_data_mem #(
    parameter int dmem_words = 1024
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            write_en,
    input  logic [tinker_isa_pkg::xlen-1:0] addr,
    input  logic [tinker_isa_pkg::xlen-1:0] write_data,
    output logic [tinker_isa_pkg::xlen-1:0] read_data
);

    localparam int aw = $clog2(dmem_words);

    logic [tinker_isa_pkg::xlen-1:0] mem [dmem_words];
    logic [aw-1:0]                   idx;

    // byte address, low three bits ignored
    assign idx       = addr[aw+2:3];
    assign read_data = mem[idx];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < dmem_words; i++) begin
                mem[i] <= '0;
            end
        end else if (write_en) begin
            mem[idx] <= write_data;
        end
    end

    // store address from execute must be word aligned and in range
    a_store_addr: assert property (@(posedge clk) disable iff (reset)
        write_en |-> (addr[2:0] == 3'b000 && addr < 64'(dmem_words) * 64'd8));

endmodule

// ==== hdl/tinker_forward.sv ====
module tinker_forward (
    input  tinker_pipe_pkg::decoded_t       id_ex,
    input  tinker_pipe_pkg::ex_mem_t        ex_mem,
    input  logic [tinker_isa_pkg::xlen-1:0] mem_result,
    input  tinker_pipe_pkg::wb_t            wb,
    output logic [tinker_isa_pkg::xlen-1:0] rd_fwd,
    output logic [tinker_isa_pkg::xlen-1:0] rs_fwd,
    output logic [tinker_isa_pkg::xlen-1:0] rt_fwd
);

    // newest producer wins, ex/mem ahead of writeback
    function automatic logic [tinker_isa_pkg::xlen-1:0] newest(
        input tinker_isa_pkg::reg_addr_t       r,
        input logic [tinker_isa_pkg::xlen-1:0] dec_val
    );
        if (ex_mem.valid && ex_mem.reg_write && ex_mem.rd == r) begin
            // loaded word already selected by the memory stage
            return mem_result;
        end else if (wb.valid && wb.rd == r) begin
            return wb.data;
        end
        return dec_val;
    endfunction

    always_comb begin
        rd_fwd = newest(id_ex.rd, id_ex.rd_val);
        rs_fwd = newest(id_ex.rs, id_ex.rs_val);
        rt_fwd = newest(id_ex.rt, id_ex.rt_val);
    end

endmodule

// ==== hdl/tinker_regfile.sv ====
module tinker_regfile (
    input  logic                            clk,
    input  logic                            reset,
    input  tinker_isa_pkg::reg_addr_t       rd_addr,
    input  tinker_isa_pkg::reg_addr_t       rs_addr,
    input  tinker_isa_pkg::reg_addr_t       rt_addr,
    output logic [tinker_isa_pkg::xlen-1:0] rd_val,
    output logic [tinker_isa_pkg::xlen-1:0] rs_val,
    output logic [tinker_isa_pkg::xlen-1:0] rt_val,
    input  tinker_pipe_pkg::wb_t            wb
);

    // r0 is an ordinary register here
    logic [tinker_isa_pkg::xlen-1:0] regs [32];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // write-through so decode sees the value retiring this cycle
    assign rd_val = (wb.valid && wb.rd == rd_addr) ? wb.data : regs[rd_addr];
    assign rs_val = (wb.valid && wb.rd == rs_addr) ? wb.data : regs[rs_addr];
    assign rt_val = (wb.valid && wb.rd == rt_addr) ? wb.data : regs[rt_addr];

endmodule

// ==== hdl/tinker_pipe_pkg.sv ====
package tinker_pipe_pkg;

    // if/id register
    typedef struct packed {
        logic                            valid;
        logic [tinker_isa_pkg::xlen-1:0] pc;
        tinker_isa_pkg::instr_t          instr;
    } fetch_t;

    // id/ex register, operands as read in decode
    typedef struct packed {
        logic                            valid;
        tinker_isa_pkg::opcode_t         op;
        tinker_isa_pkg::reg_addr_t       rd;
        tinker_isa_pkg::reg_addr_t       rs;
        tinker_isa_pkg::reg_addr_t       rt;
        // second operand comes from the literal
        logic                            lit_sel;
        logic [tinker_isa_pkg::xlen-1:0] literal;
        logic [tinker_isa_pkg::xlen-1:0] pc;
        logic [tinker_isa_pkg::xlen-1:0] rd_val;
        logic [tinker_isa_pkg::xlen-1:0] rs_val;
        logic [tinker_isa_pkg::xlen-1:0] rt_val;
    } decoded_t;

    // ex/mem register
    typedef struct packed {
        logic                            valid;
        tinker_isa_pkg::reg_addr_t       rd;
        logic                            reg_write;
        logic                            mem_write;
        logic                            is_load;
        logic [tinker_isa_pkg::xlen-1:0] result;
        logic [tinker_isa_pkg::xlen-1:0] addr;
        logic [tinker_isa_pkg::xlen-1:0] store_data;
        logic                            redirect;
        logic [tinker_isa_pkg::xlen-1:0] target;
        logic                            halt;
    } ex_mem_t;

    // register writeback
    typedef struct packed {
        logic                            valid;
        tinker_isa_pkg::reg_addr_t       rd;
        logic [tinker_isa_pkg::xlen-1:0] data;
    } wb_t;

endpackage

// ==== hdl/tinker_isa_pkg.sv ====
package tinker_isa_pkg;

    // datapath width
    localparam int xlen = 64;
    // instruction word width
    localparam int ilen = 32;

    typedef logic [4:0]  reg_addr_t;
    typedef logic [11:0] lit_t;

    // kept subset of the tinker opcode map
    typedef enum logic [4:0] {
        op_and        = 5'h00,
        op_or         = 5'h01,
        op_xor        = 5'h02,
        op_not        = 5'h03,
        op_shftr      = 5'h04,
        op_shftri     = 5'h05,
        op_shftl      = 5'h06,
        op_shftli     = 5'h07,
        op_brr        = 5'h08,
        op_brr_rel    = 5'h09,
        op_br_rel_lit = 5'h0a,
        op_brnz       = 5'h0b,
        op_brgt       = 5'h0e,
        op_halt       = 5'h0f,
        op_load       = 5'h10,
        op_mov        = 5'h11,
        op_movl       = 5'h12,
        op_store      = 5'h13,
        op_add        = 5'h18,
        op_addi       = 5'h19,
        op_sub        = 5'h1a,
        op_subi       = 5'h1b,
        op_mul        = 5'h1c
    } opcode_t;

    // op in the top five bits, literal at the bottom
    typedef struct packed {
        opcode_t   op;
        reg_addr_t rd;
        reg_addr_t rs;
        reg_addr_t rt;
        lit_t      lit;
    } instr_t;

endpackage
